// ==== logic/div_pkg.sv ====
// shared word types, core states and queue/credit sizes for the divide unit and its testbench
`default_nettype none

package div_pkg;

    // operand, quotient and remainder
    typedef logic [31:0] word_t;

    // partial remainder or divisor with one guard bit on top
    typedef logic [32:0] wide_t;

    // shift amounts and leading zero counts, 0 to 32
    typedef logic [5:0] shift_t;

    typedef enum logic [2:0] {
        IDLE,
        NORMALIZE,
        ITERATE,
        CORRECT,
        HOLD
    } div_state_t;

    // request slots, also the sender's starting credit
    localparam int QUEUE_DEPTH = 4;

    // results the core may send before the first credit comes back
    localparam int RESULT_CREDITS = 2;

    localparam int CREDIT_MAX = (QUEUE_DEPTH > RESULT_CREDITS) ? QUEUE_DEPTH : RESULT_CREDITS;

    // must hold CREDIT_MAX itself, not just CREDIT_MAX-1
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

endpackage

`default_nettype wire

// ==== logic/div_op_if.sv ====
// one queued division request passed from the operand queue to the divider core
`timescale 1ns/1ps
`default_nettype none

interface div_op_if;

    logic              op_valid;
    div_pkg::word_t    op_dividend;
    div_pkg::word_t    op_divisor;
    logic              op_signed;
    logic              op_rem;
    logic              op_pop;

    modport queue (
        output op_valid,
        output op_dividend,
        output op_divisor,
        output op_signed,
        output op_rem,
        input  op_pop
    );

    modport core (
        input  op_valid,
        input  op_dividend,
        input  op_divisor,
        input  op_signed,
        input  op_rem,
        output op_pop
    );

endinterface

`default_nettype wire

// ==== logic/leading_zero_count.sv ====
// combinational leading zero count of a 32-bit word, 32 when the word is zero
`timescale 1ns/1ps
`default_nettype none

module leading_zero_count (
    input  div_pkg::word_t  data,
    output div_pkg::shift_t zero_count
);

    // leading zeros inside one byte, 8 if the byte is empty
    function automatic logic [3:0] byte_lz(input logic [7:0] b);
        logic [3:0] n;
        n = 4'd8;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                n = 4'(7 - i);
            end
        end
        return n;
    endfunction

    logic [3:0] byte_count [4];
    logic [3:0] byte_hit;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            byte_count[k] = byte_lz(data[k*8 +: 8]);
            byte_hit[k]   = |data[k*8 +: 8];
        end
    end

    // highest non-empty byte wins, so scan upward and let later hits overwrite
    always_comb begin
        zero_count = div_pkg::shift_t'(32);
        for (int k = 0; k < 4; k++) begin
            if (byte_hit[k]) begin
                zero_count = div_pkg::shift_t'((3 - k) * 8)
                           + div_pkg::shift_t'(byte_count[k]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/div_op_queue.sv ====
// request FIFO in front of the divider core, hands one credit back upstream per popped entry
`timescale 1ns/1ps
`default_nettype none

module div_op_queue (
    input  logic           clk,
    input  logic           reset,
    input  logic           req_valid,
    input  logic           req_signed,
    input  logic           req_rem,
    input  div_pkg::word_t req_dividend,
    input  div_pkg::word_t req_divisor,
    output logic           req_credit,
    div_op_if.queue        op
);

    localparam int PTR_W = $clog2(div_pkg::QUEUE_DEPTH);

    div_pkg::word_t dividend_mem [div_pkg::QUEUE_DEPTH];
    div_pkg::word_t divisor_mem  [div_pkg::QUEUE_DEPTH];
    logic           signed_mem   [div_pkg::QUEUE_DEPTH];
    logic           rem_mem      [div_pkg::QUEUE_DEPTH];

    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [div_pkg::CREDIT_W-1:0] count;

    // payload write
    always_ff @(posedge clk) begin
        if (req_valid) begin
            dividend_mem[wr_ptr] <= req_dividend;
            divisor_mem[wr_ptr]  <= req_divisor;
            signed_mem[wr_ptr]   <= req_signed;
            rem_mem[wr_ptr]      <= req_rem;
        end
    end

    // pointers wrap by themselves at the power-of-two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            req_credit <= op.op_pop;
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (op.op_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, op.op_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry stays put until the core pops it
    assign op.op_valid    = (count != '0);
    assign op.op_dividend = dividend_mem[rd_ptr];
    assign op.op_divisor  = divisor_mem[rd_ptr];
    assign op.op_signed   = signed_mem[rd_ptr];
    assign op.op_rem      = rem_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/srt_div_core.sv ====
// radix-2 SRT divider, one request at a time, result sent only against a consumer credit
`timescale 1ns/1ps
`default_nettype none

module srt_div_core (
    input  logic           clk,
    input  logic           reset,
    div_op_if.core         op,
    input  logic           res_credit,
    output logic           result_valid,
    output logic           result_div_zero,
    output div_pkg::word_t result
);

    div_pkg::div_state_t state;

    div_pkg::wide_t  pr;
    div_pkg::wide_t  dvs;
    div_pkg::wide_t  dvs_neg;
    div_pkg::word_t  q_pos;
    div_pkg::word_t  q_neg;
    div_pkg::word_t  dividend_q;
    div_pkg::shift_t iter_left;
    div_pkg::shift_t rem_shift;
    logic            q_sign;
    logic            r_sign;
    logic            rem_sel;
    div_pkg::word_t  res_word;
    logic            res_zero;

    logic [div_pkg::CREDIT_W-1:0] credits;

    div_pkg::shift_t lz_pr;
    div_pkg::shift_t lz_pr_inv;
    div_pkg::shift_t lz_dvs;
    div_pkg::shift_t pr_lead;
    div_pkg::wide_t  dvs_norm;
    div_pkg::wide_t  pr_step;
    logic            dig_pos;
    logic            dig_neg;
    div_pkg::word_t  a_mag;
    div_pkg::word_t  b_mag;
    div_pkg::wide_t  rem_fix;
    div_pkg::word_t  rem_mag;
    div_pkg::word_t  quo_fix;
    div_pkg::word_t  quo_out;
    div_pkg::word_t  rem_out;
    logic            send;

    leading_zero_count u_lz_dividend (
        .data       (pr[31:0]),
        .zero_count (lz_pr)
    );

    leading_zero_count u_lz_pr_inv (
        .data       (~pr[31:0]),
        .zero_count (lz_pr_inv)
    );

    leading_zero_count u_lz_divisor (
        .data       (dvs[31:0]),
        .zero_count (lz_dvs)
    );

    // redundant sign bits of the partial remainder
    assign pr_lead  = pr[32] ? lz_pr_inv : lz_pr;
    assign dvs_norm = dvs << lz_dvs;

    assign a_mag = (op.op_signed && op.op_dividend[31]) ? -op.op_dividend : op.op_dividend;
    assign b_mag = (op.op_signed && op.op_divisor[31])  ? -op.op_divisor  : op.op_divisor;

    // 01 picks digit +1 and 10 picks -1 while 00 and 11 give 0
    always_comb begin
        pr_step = pr;
        dig_pos = 1'b0;
        dig_neg = 1'b0;
        case (pr[32:31])
            2'b01: begin
                pr_step = pr + dvs_neg;
                dig_pos = 1'b1;
            end
            2'b10: begin
                pr_step = pr + dvs;
                dig_neg = 1'b1;
            end
            default: begin
                pr_step = pr;
            end
        endcase
    end

    // one add-back when the last remainder came out negative
    assign rem_fix = pr[32] ? pr + dvs : pr;
    assign rem_mag = div_pkg::word_t'(rem_fix >> rem_shift);
    assign quo_fix = q_pos - q_neg - div_pkg::word_t'(pr[32]);
    assign quo_out = q_sign ? -quo_fix : quo_fix;
    assign rem_out = r_sign ? -rem_mag : rem_mag;

    assign op.op_pop       = (state == div_pkg::IDLE) && op.op_valid;
    assign send            = (state == div_pkg::HOLD) && (credits != '0);
    assign result_valid    = send;
    assign result          = res_word;
    assign result_div_zero = res_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= div_pkg::IDLE;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (op.op_valid) begin
                        pr         <= {1'b0, a_mag};
                        dvs        <= {1'b0, b_mag};
                        dividend_q <= op.op_dividend;
                        q_sign     <= op.op_signed & (op.op_dividend[31] ^ op.op_divisor[31]);
                        r_sign     <= op.op_signed & op.op_dividend[31];
                        rem_sel    <= op.op_rem;
                        state      <= div_pkg::NORMALIZE;
                    end
                end
                div_pkg::NORMALIZE: begin
                    res_zero <= 1'b0;
                    if (dvs[31:0] == '0) begin
                        res_word <= rem_sel ? dividend_q : '1;
                        res_zero <= 1'b1;
                        state    <= div_pkg::HOLD;
                    end else if (pr[31:0] < dvs[31:0]) begin
                        res_word <= rem_sel ? dividend_q : '0;
                        state    <= div_pkg::HOLD;
                    end else begin
                        // both operands end up with bit 31 set
                        pr        <= pr << pr_lead;
                        dvs       <= dvs_norm;
                        dvs_neg   <= -dvs_norm;
                        q_pos     <= '0;
                        q_neg     <= '0;
                        iter_left <= lz_dvs - pr_lead + 6'd1;
                        rem_shift <= lz_dvs;
                        state     <= div_pkg::ITERATE;
                    end
                end
                div_pkg::ITERATE: begin
                    q_pos     <= {q_pos[30:0], dig_pos};
                    q_neg     <= {q_neg[30:0], dig_neg};
                    iter_left <= iter_left - 6'd1;
                    if (iter_left == 6'd1) begin
                        // last digit is not shifted
                        pr    <= pr_step;
                        state <= div_pkg::CORRECT;
                    end else begin
                        pr <= pr_step << 1;
                    end
                end
                div_pkg::CORRECT: begin
                    res_word <= rem_sel ? rem_out : quo_out;
                    state    <= div_pkg::HOLD;
                end
                div_pkg::HOLD: begin
                    if (send) begin
                        state <= div_pkg::IDLE;
                    end
                end
                default: begin
                    state <= div_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= div_pkg::CREDIT_W'(div_pkg::RESULT_CREDITS);
        end else begin
            case ({res_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/div_unit_top.sv ====
// divide unit top level, request queue feeding the SRT core, plain request/result/credit ports
`timescale 1ns/1ps
`default_nettype none

module div_unit_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           req_valid,
    input  div_pkg::word_t req_dividend,
    input  div_pkg::word_t req_divisor,
    input  logic           req_signed,
    input  logic           req_rem,
    output logic           req_credit,
    output logic           result_valid,
    output div_pkg::word_t result,
    output logic           result_div_zero,
    input  logic           res_credit
);

    div_op_if op_bus ();

    div_op_queue u_queue (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_signed   (req_signed),
        .req_rem      (req_rem),
        .req_dividend (req_dividend),
        .req_divisor  (req_divisor),
        .req_credit   (req_credit),
        .op           (op_bus.queue)
    );

    // results leave in request order, one per granted credit
    srt_div_core u_core (
        .clk             (clk),
        .reset           (reset),
        .op              (op_bus.core),
        .res_credit      (res_credit),
        .result_valid    (result_valid),
        .result_div_zero (result_div_zero),
        .result          (result)
    );

endmodule

`default_nettype wire

// ==== sim/div_clock_gen.sv ====
// testbench clock and reset source for the divide unit, 40 ns period with reset over three edges
`timescale 1ns/1ps
`default_nettype none

module div_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // released on the third rising edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/div_unit_asserts.sv ====
// concurrent checks on queue occupancy, result credits and reset values, bound into div_unit_top
`timescale 1ns/1ps
`default_nettype none

module div_unit_asserts (
    input logic                         clk,
    input logic                         reset,
    input logic [div_pkg::CREDIT_W-1:0] occupancy,
    input logic                         res_credit,
    input logic                         req_credit,
    input logic                         op_pop,
    input logic                         result_valid
);

    // count of failed assertions for the end of the run
    int fail_count = 0;

    // result credits the consumer has granted and not yet used
    logic [div_pkg::CREDIT_W-1:0] granted;

    always_ff @(posedge clk) begin
        if (reset) begin
            granted <= div_pkg::CREDIT_W'(div_pkg::RESULT_CREDITS);
        end else begin
            granted <= granted + div_pkg::CREDIT_W'(res_credit)
                     - div_pkg::CREDIT_W'(result_valid);
        end
    end

    occupancy_in_range: assert property (@(posedge clk) disable iff (reset)
        occupancy <= div_pkg::CREDIT_W'(div_pkg::QUEUE_DEPTH))
    else begin
        $error("queue occupancy above its depth");
        fail_count++;
    end

    result_needs_credit: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (granted != '0))
    else begin
        $error("result sent with no result credit left");
        fail_count++;
    end

    // handshake outputs quiet right after reset
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!req_credit && !op_pop && !result_valid))
    else begin
        $error("handshake output high in the first cycle after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== sim/div_unit_tb.sv ====
// divide unit testbench, directed and random requests under credit flow, results checked in order
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

    typedef struct packed {
        div_pkg::word_t a;
        div_pkg::word_t b;
        logic           sgn;
        logic           rem;
        div_pkg::word_t exp;
        logic           zero;
    } vec_t;

    logic           clk;
    logic           reset;
    logic           req_valid;
    div_pkg::word_t req_dividend;
    div_pkg::word_t req_divisor;
    logic           req_signed;
    logic           req_rem;
    logic           req_credit;
    logic           result_valid;
    div_pkg::word_t result;
    logic           result_div_zero;
    logic           res_credit;

    vec_t   vectors [$];
    vec_t   expected_q [$];
    integer seed = 2187;
    int     send_credits = div_pkg::QUEUE_DEPTH;
    int     cons_credits = div_pkg::RESULT_CREDITS;
    int     credit_pulses = 0;
    int     results_seen = 0;

    div_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    div_unit_top dut (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_dividend    (req_dividend),
        .req_divisor     (req_divisor),
        .req_signed      (req_signed),
        .req_rem         (req_rem),
        .req_credit      (req_credit),
        .result_valid    (result_valid),
        .result          (result),
        .result_div_zero (result_div_zero),
        .res_credit      (res_credit)
    );

    bind div_unit_top div_unit_asserts u_asserts (
        .clk          (clk),
        .reset        (reset),
        .occupancy    (u_queue.count),
        .res_credit   (res_credit),
        .req_credit   (req_credit),
        .op_pop       (op_bus.op_pop),
        .result_valid (result_valid)
    );

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "divide unit run stopped on an error");
    endtask

    task automatic check_word(input div_pkg::word_t got, input div_pkg::word_t exp,
                              input string ctx);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s result %h, expected %h", $time, ctx, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string ctx);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s div_zero %b, expected %b", $time, ctx, got, exp);
            stop_with_failure();
        end
    endtask

    // truncating division with the remainder taking the dividend's sign
    function automatic div_pkg::word_t model_result(input div_pkg::word_t a,
                                                    input div_pkg::word_t b,
                                                    input logic sgn, input logic rem);
        div_pkg::word_t q;
        div_pkg::word_t r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            q = div_pkg::word_t'($signed(a) / $signed(b));
            r = div_pkg::word_t'($signed(a) % $signed(b));
        end else begin
            q = a / b;
            r = a % b;
        end
        return rem ? r : q;
    endfunction

    function automatic vec_t make_vec(input div_pkg::word_t a, input div_pkg::word_t b,
                                      input logic sgn, input logic rem);
        vec_t v;
        v.a    = a;
        v.b    = b;
        v.sgn  = sgn;
        v.rem  = rem;
        v.exp  = model_result(a, b, sgn, rem);
        v.zero = (b == '0);
        return v;
    endfunction

    function automatic vec_t directed_row(input div_pkg::word_t a, input div_pkg::word_t b,
                                          input logic sgn, input logic rem,
                                          input div_pkg::word_t exp, input logic zero);
        vec_t v;
        v = '{a, b, sgn, rem, exp, zero};
        return v;
    endfunction

    // dividend, divisor, signed, remainder select, expected result, expected div_zero
    task automatic load_directed();
        vectors.push_back(directed_row(32'd100, 32'd7, 1'b0, 1'b0, 32'd14, 1'b0));
        vectors.push_back(directed_row(32'd100, 32'd7, 1'b0, 1'b1, 32'd2, 1'b0));
        vectors.push_back(directed_row(32'd5, 32'd9, 1'b0, 1'b0, 32'd0, 1'b0));
        vectors.push_back(directed_row(32'd5, 32'd9, 1'b0, 1'b1, 32'd5, 1'b0));
        vectors.push_back(directed_row(32'd12345, 32'd12345, 1'b0, 1'b0, 32'd1, 1'b0));
        vectors.push_back(directed_row(32'd12345, 32'd12345, 1'b0, 1'b1, 32'd0, 1'b0));
        vectors.push_back(directed_row(32'hffffffff, 32'd1, 1'b0, 1'b0, 32'hffffffff, 1'b0));
        vectors.push_back(directed_row(32'hffffffff, 32'd10, 1'b0, 1'b0, 32'h19999999, 1'b0));
        vectors.push_back(directed_row(32'hffffffff, 32'd10, 1'b0, 1'b1, 32'd5, 1'b0));
        vectors.push_back(directed_row(32'hdeadbeef, 32'h10, 1'b0, 1'b0, 32'h0deadbee, 1'b0));
        vectors.push_back(directed_row(32'hfffffff9, 32'd2, 1'b1, 1'b0, 32'hfffffffd, 1'b0));
        vectors.push_back(directed_row(32'hfffffff9, 32'd2, 1'b1, 1'b1, 32'hffffffff, 1'b0));
        vectors.push_back(directed_row(32'd7, 32'hfffffffe, 1'b1, 1'b0, 32'hfffffffd, 1'b0));
        vectors.push_back(directed_row(32'd7, 32'hfffffffe, 1'b1, 1'b1, 32'd1, 1'b0));
        vectors.push_back(directed_row(32'hfffffff9, 32'hfffffffe, 1'b1, 1'b0, 32'd3, 1'b0));
        vectors.push_back(directed_row(32'hffffff9c, 32'd7, 1'b1, 1'b1, 32'hfffffffe, 1'b0));
        vectors.push_back(directed_row(32'h80000000, 32'hffffffff, 1'b1, 1'b0, 32'h80000000, 1'b0));
        vectors.push_back(directed_row(32'h80000000, 32'hffffffff, 1'b1, 1'b1, 32'd0, 1'b0));
        vectors.push_back(directed_row(32'h80000000, 32'hffffffff, 1'b0, 1'b1, 32'h80000000, 1'b0));
        vectors.push_back(directed_row(32'd1234, 32'd0, 1'b0, 1'b0, 32'hffffffff, 1'b1));
        vectors.push_back(directed_row(32'd1234, 32'd0, 1'b0, 1'b1, 32'd1234, 1'b1));
        vectors.push_back(directed_row(32'hfffffff0, 32'd0, 1'b1, 1'b0, 32'hffffffff, 1'b1));
        vectors.push_back(directed_row(32'hfffffff0, 32'd0, 1'b1, 1'b1, 32'hfffffff0, 1'b1));
    endtask

    // advance one clock and pick up any returned request credit
    task automatic next_cycle();
        @(posedge clk);
        if (req_credit) begin
            send_credits = send_credits + 1;
        end
    endtask

    task automatic send_request(input vec_t v);
        while (send_credits == 0) begin
            req_valid <= 1'b0;
            next_cycle();
        end
        req_valid    <= 1'b1;
        req_dividend <= v.a;
        req_divisor  <= v.b;
        req_signed   <= v.sgn;
        req_rem      <= v.rem;
        send_credits = send_credits - 1;
        expected_q.push_back(v);
        next_cycle();
    endtask

    always @(posedge clk) begin
        if (!reset && req_credit) begin
            credit_pulses <= credit_pulses + 1;
        end
    end

    // result consumer that hands credits back after 0 to 5 cycles
    initial begin : consumer
        vec_t  v;
        string ctx;
        int    due_q [$];
        int    cycle_n;
        res_credit = 1'b0;
        cycle_n    = 0;
        forever begin
            @(posedge clk);
            cycle_n++;
            if (!reset && result_valid) begin
                if (cons_credits == 0) begin
                    $display("error at %0t: result arrived with no credit granted", $time);
                    stop_with_failure();
                end
                if (expected_q.size() == 0) begin
                    $display("error at %0t: result arrived with no request pending", $time);
                    stop_with_failure();
                end
                v   = expected_q.pop_front();
                ctx = $sformatf("a=%h b=%h signed=%b rem=%b", v.a, v.b, v.sgn, v.rem);
                check_word(result, v.exp, ctx);
                check_flag(result_div_zero, v.zero, ctx);
                results_seen++;
                cons_credits--;
                due_q.push_back(cycle_n + int'($unsigned($random(seed)) % 6));
            end
            if (due_q.size() != 0 && due_q[0] <= cycle_n) begin
                void'(due_q.pop_front());
                res_credit <= 1'b1;
                cons_credits++;
            end else begin
                res_credit <= 1'b0;
            end
        end
    end

    initial begin : main
        div_pkg::word_t a;
        div_pkg::word_t b;
        div_pkg::word_t r;
        int             watch_cycles;
        req_valid    = 1'b0;
        req_dividend = '0;
        req_divisor  = '0;
        req_signed   = 1'b0;
        req_rem      = 1'b0;
        load_directed();
        for (int i = 0; i < 200; i++) begin
            a = $random(seed);
            b = $random(seed);
            r = $random(seed);
            // spread divisor sizes and now and then force a zero
            b = b >> r[6:2];
            if (r[11:8] == 4'd0) begin
                b = '0;
            end
            vectors.push_back(make_vec(a, b, r[0], r[1]));
        end
        watch_cycles = vectors.size() * 40 + 200;
        fork
            begin
                #(watch_cycles * 40);
                $display("timeout: only %0d of %0d results came back within %0d cycles",
                         results_seen, vectors.size(), watch_cycles);
                stop_with_failure();
            end
        join_none
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        foreach (vectors[i]) begin
            send_request(vectors[i]);
        end
        req_valid <= 1'b0;
        while (results_seen < vectors.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (credit_pulses != vectors.size()) begin
            $display("error: %0d request credits returned for %0d requests",
                     credit_pulses, vectors.size());
            stop_with_failure();
        end else if (dut.u_asserts.fail_count != 0) begin
            $display("error: %0d assertion failures", dut.u_asserts.fail_count);
            stop_with_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/div_pkg.sv
logic/div_op_if.sv
logic/leading_zero_count.sv
logic/div_op_queue.sv
logic/srt_div_core.sv
logic/div_unit_top.sv
sim/div_clock_gen.sv
sim/div_unit_asserts.sv
sim/div_unit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        := div_unit_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
PASS_MSG   := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
